// ==== Makefile ====
# Verilator flow for the register file subsystem

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f files.f --top-module rf_tb

sim:
	verilator --binary --timing -f files.f --top-module rf_tb -o rf_sim
	./obj_dir/rf_sim | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/cmd_fifo.sv ====
`include "rf_config.svh"

module cmd_fifo #(
  parameter int unsigned DEPTH = `RF_CMD_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   reset_i,

  // Push side
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  rf_cmd_pkg::cmd_op_e    in_op_i,
  input  rf_types_pkg::rf_addr_t in_addr_a_i,
  input  rf_types_pkg::rf_addr_t in_addr_b_i,
  input  rf_types_pkg::rf_data_t in_wdata_i,
  input  logic                   in_inject_i,

  // Pop side
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output rf_cmd_pkg::cmd_op_e    out_op_o,
  output rf_types_pkg::rf_addr_t out_addr_a_o,
  output rf_types_pkg::rf_addr_t out_addr_b_o,
  output rf_types_pkg::rf_data_t out_wdata_o,
  output logic                   out_inject_o
);

  import rf_types_pkg::*;
  import rf_cmd_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  // Command fields kept side by side
  cmd_op_e  op_q     [DEPTH];
  rf_addr_t addr_a_q [DEPTH];
  rf_addr_t addr_b_q [DEPTH];
  rf_data_t wdata_q  [DEPTH];
  logic     inject_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic push;
  logic pop;
  logic full;

  assign full = (count_q == FULL_CNT);

  // Full buffer still takes a command when the head leaves this cycle
  assign in_ready_o  = !full || out_ready_i;
  assign out_valid_o = (count_q != '0);

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  // Head entry drives the output directly
  assign out_op_o     = op_q[rd_ptr_q];
  assign out_addr_a_o = addr_a_q[rd_ptr_q];
  assign out_addr_b_o = addr_b_q[rd_ptr_q];
  assign out_wdata_o  = wdata_q[rd_ptr_q];
  assign out_inject_o = inject_q[rd_ptr_q];

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count only moves when exactly one side fires
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr_q]     <= in_op_i;
      addr_a_q[wr_ptr_q] <= in_addr_a_i;
      addr_b_q[wr_ptr_q] <= in_addr_b_i;
      wdata_q[wr_ptr_q]  <= in_wdata_i;
      inject_q[wr_ptr_q] <= in_inject_i;
    end
  end

endmodule

// ==== design/register_file.sv ====
`include "rf_config.svh"

module register_file (
  input  logic                   clk,
  input  logic                   reset_i,

  // Read ports
  input  rf_types_pkg::rf_addr_t raddr_i [`RF_NUM_READ_PORTS],
  output rf_types_pkg::rf_word_t rdata_o [`RF_NUM_READ_PORTS],

  // Write port
  input  rf_types_pkg::rf_addr_t waddr_i,
  input  rf_types_pkg::rf_word_t wdata_i,
  input  logic                   we_i
);

  import rf_types_pkg::*;

  //////////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////////

  // Register 0 has no storage
  rf_word_t regs_q [1:`RF_NUM_REGS-1];

  logic write_en;

  // Writes to register 0 are dropped
  assign write_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      // Zero codeword has zero check bits, so cleared registers read clean
      for (int r = 1; r < `RF_NUM_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (write_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////////

  // Purely combinational, new data visible after the write edge
  generate
    for (genvar p = 0; p < `RF_NUM_READ_PORTS; p++) begin : g_rd_port
      always_comb begin
        if (raddr_i[p] == '0) begin
          rdata_o[p] = '0;
        end else begin
          rdata_o[p] = regs_q[raddr_i[p]];
        end
      end
    end
  endgenerate

endmodule

// ==== design/register_file_ecc.sv ====
`include "rf_config.svh"

module register_file_ecc (
  // Write path
  input  rf_types_pkg::rf_data_t wdata_i,
  output rf_types_pkg::rf_word_t rf_wdata_o,

  // Read paths
  input  rf_types_pkg::rf_word_t rdata_i [`RF_NUM_READ_PORTS],

  // Any port carries a bad codeword
  output logic                   ecc_err_o
);

  import rf_types_pkg::*;

  //////////////////////////////////////////////////////////////////////////
  // Hsiao (39,32) parity masks
  //////////////////////////////////////////////////////////////////////////

  // One row per check bit
  // Every data column has odd weight, so single flips never alias to zero
  localparam rf_data_t HSIAO_MASK [`RF_ECC_WIDTH] = '{
    32'h2606_BD25,
    32'hDEBA_8050,
    32'h413D_89AA,
    32'h3123_4ED1,
    32'hC2C1_323B,
    32'h2DCC_624C,
    32'h9850_5586
  };

  //////////////////////////////////////////////////////////////////////////
  // Encoder
  //////////////////////////////////////////////////////////////////////////

  rf_ecc_t wr_check;

  always_comb begin
    for (int i = 0; i < `RF_ECC_WIDTH; i++) begin
      wr_check[i] = ^(wdata_i & HSIAO_MASK[i]);
    end
  end

  // Check bits above the data
  assign rf_wdata_o = {wr_check, wdata_i};

  //////////////////////////////////////////////////////////////////////////
  // Syndrome check
  //////////////////////////////////////////////////////////////////////////

  rf_data_t rd_data   [`RF_NUM_READ_PORTS];
  rf_ecc_t  rd_check  [`RF_NUM_READ_PORTS];
  rf_ecc_t  syndrome  [`RF_NUM_READ_PORTS];
  logic [`RF_NUM_READ_PORTS-1:0] port_err;

  generate
    for (genvar p = 0; p < `RF_NUM_READ_PORTS; p++) begin : g_chk_port
      assign rd_data[p]  = rdata_i[p][`RF_DATA_WIDTH-1:0];
      assign rd_check[p] = rdata_i[p][`RF_DATA_WIDTH +: `RF_ECC_WIDTH];

      // Recompute check bits and compare against the stored ones
      always_comb begin
        for (int i = 0; i < `RF_ECC_WIDTH; i++) begin
          syndrome[p][i] = rd_check[p][i] ^ (^(rd_data[p] & HSIAO_MASK[i]));
        end
      end

      // Detection only, nonzero syndrome is an error
      assign port_err[p] = |syndrome[p];
    end
  endgenerate

  assign ecc_err_o = |port_err;

endmodule

// ==== design/register_file_wrapper.sv ====
`include "rf_config.svh"

module register_file_wrapper (
  input  logic                   clk,
  input  logic                   reset_i,

  // Read ports
  input  rf_types_pkg::rf_addr_t raddr_i [`RF_NUM_READ_PORTS],
  output rf_types_pkg::rf_data_t rdata_o [`RF_NUM_READ_PORTS],

  // Write port
  input  rf_types_pkg::rf_addr_t waddr_i,
  input  rf_types_pkg::rf_data_t wdata_i,
  input  logic                   we_i,
  input  logic                   inject_i,

  // ECC
  output logic                   ecc_err_o
);

  import rf_types_pkg::*;

  rf_word_t enc_wdata;
  rf_word_t inject_mask;
  rf_word_t store_wdata;
  rf_word_t rf_rdata [`RF_NUM_READ_PORTS];

  // Self test flips data bit 0 of the codeword
  assign inject_mask = rf_word_t'(inject_i);
  assign store_wdata = enc_wdata ^ inject_mask;

  register_file register_file_i (
    .clk     (clk),
    .reset_i (reset_i),
    .raddr_i (raddr_i),
    .rdata_o (rf_rdata),
    .waddr_i (waddr_i),
    .wdata_i (store_wdata),
    .we_i    (we_i)
  );

  register_file_ecc register_file_ecc_i (
    .wdata_i    (wdata_i),
    .rf_wdata_o (enc_wdata),
    .rdata_i    (rf_rdata),
    .ecc_err_o  (ecc_err_o)
  );

  // Strip check bits, a corrupted bit is returned as stored
  generate
    for (genvar p = 0; p < `RF_NUM_READ_PORTS; p++) begin : g_strip
      assign rdata_o[p] = rf_rdata[p][`RF_DATA_WIDTH-1:0];
    end
  endgenerate

endmodule

// ==== design/rf_access_ctrl.sv ====
module rf_access_ctrl (
  input  logic                   clk,
  input  logic                   reset_i,

  // Command from the buffer
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  rf_cmd_pkg::cmd_op_e    cmd_op_i,
  input  rf_types_pkg::rf_addr_t cmd_addr_a_i,
  input  rf_types_pkg::rf_addr_t cmd_addr_b_i,
  input  rf_types_pkg::rf_data_t cmd_wdata_i,
  input  logic                   cmd_inject_i,

  // Register file access
  output rf_types_pkg::rf_addr_t rf_raddr_a_o,
  output rf_types_pkg::rf_addr_t rf_raddr_b_o,
  output rf_types_pkg::rf_addr_t rf_waddr_o,
  output rf_types_pkg::rf_data_t rf_wdata_o,
  output logic                   rf_we_o,
  output logic                   rf_inject_o,
  input  rf_types_pkg::rf_data_t rf_rdata_a_i,
  input  rf_types_pkg::rf_data_t rf_rdata_b_i,
  input  logic                   rf_ecc_err_i,

  // Read response
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output rf_types_pkg::rf_data_t rsp_rdata_a_o,
  output rf_types_pkg::rf_data_t rsp_rdata_b_o,
  output logic                   rsp_ecc_err_o
);

  import rf_types_pkg::*;
  import rf_cmd_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  logic pop;
  logic pop_read;

  rf_data_t rsp_rdata_a_q;
  rf_data_t rsp_rdata_b_q;
  logic     rsp_ecc_err_q;

  // Commands only leave the buffer while idle
  assign cmd_ready_o = (state_q == CTRL_IDLE);
  assign pop         = cmd_valid_i && cmd_ready_o;
  assign pop_read    = pop && (cmd_op_i == CMD_READ);

  // Addresses straight from the head command
  assign rf_raddr_a_o = cmd_addr_a_i;
  assign rf_raddr_b_o = cmd_addr_b_i;
  assign rf_waddr_o   = cmd_addr_a_i;
  assign rf_wdata_o   = cmd_wdata_i;
  assign rf_inject_o  = cmd_inject_i;

  // One cycle write enable per popped write
  assign rf_we_o = pop && (cmd_op_i == CMD_WRITE);

  //////////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (pop_read) begin
          state_d = CTRL_RESP;
        end
      end
      CTRL_RESP: begin
        // Leave once the consumer has taken the words
        if (rsp_ready_i) begin
          state_d = CTRL_IDLE;
        end
      end
      default: state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Response payload, captured on read pop and held in RESP
  always_ff @(posedge clk) begin
    if (pop_read) begin
      rsp_rdata_a_q <= rf_rdata_a_i;
      rsp_rdata_b_q <= rf_rdata_b_i;
      rsp_ecc_err_q <= rf_ecc_err_i;
    end
  end

  assign rsp_valid_o   = (state_q == CTRL_RESP);
  assign rsp_rdata_a_o = rsp_rdata_a_q;
  assign rsp_rdata_b_o = rsp_rdata_b_q;
  assign rsp_ecc_err_o = rsp_ecc_err_q;

endmodule

// ==== design/rf_cmd_pkg.sv ====
package rf_cmd_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Command stream
  //////////////////////////////////////////////////////////////////////////

  // Opcode of one command
  // A read returns two words, a write stores one
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_op_e;

  //////////////////////////////////////////////////////////////////////////
  // Access controller
  //////////////////////////////////////////////////////////////////////////

  // Idle accepts a command
  // Resp holds a read response until the consumer takes it
  typedef enum logic {
    CTRL_IDLE = 1'b0,
    CTRL_RESP = 1'b1
  } ctrl_state_e;

endpackage

// ==== design/rf_config.svh ====
`ifndef RF_CONFIG_SVH
`define RF_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Register file geometry
////////////////////////////////////////////////////////////////////////////

// Architectural registers, register 0 included
`define RF_NUM_REGS 32

// Data bits per register
`define RF_DATA_WIDTH 32

// Hsiao check bits stored above the data
`define RF_ECC_WIDTH 7

// Read ports, one per source operand
`define RF_NUM_READ_PORTS 2

// Default depth of the command buffer
`define RF_CMD_FIFO_DEPTH 4

`endif

// ==== design/rf_subsys_top.sv ====
`include "rf_config.svh"

module rf_subsys_top (
  input  logic                   clk,
  input  logic                   reset_i,

  // Command stream
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  rf_cmd_pkg::cmd_op_e    cmd_op_i,
  input  rf_types_pkg::rf_addr_t cmd_addr_a_i,
  input  rf_types_pkg::rf_addr_t cmd_addr_b_i,
  input  rf_types_pkg::rf_data_t cmd_wdata_i,
  input  logic                   cmd_inject_i,

  // Response stream
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output rf_types_pkg::rf_data_t rsp_rdata_a_o,
  output rf_types_pkg::rf_data_t rsp_rdata_b_o,
  output logic                   rsp_ecc_err_o
);

  import rf_types_pkg::*;
  import rf_cmd_pkg::*;

  // Buffer to controller
  logic     q_valid;
  logic     q_ready;
  cmd_op_e  q_op;
  rf_addr_t q_addr_a;
  rf_addr_t q_addr_b;
  rf_data_t q_wdata;
  logic     q_inject;

  // Controller to wrapper
  rf_addr_t rf_raddr_a;
  rf_addr_t rf_raddr_b;
  rf_addr_t rf_waddr;
  rf_data_t rf_wdata;
  logic     rf_we;
  logic     rf_inject;
  logic     rf_ecc_err;
  rf_addr_t rf_raddr [`RF_NUM_READ_PORTS];
  rf_data_t rf_rdata [`RF_NUM_READ_PORTS];

  // Port 0 carries operand a, port 1 operand b
  assign rf_raddr[0] = rf_raddr_a;
  assign rf_raddr[1] = rf_raddr_b;

  cmd_fifo #(
    .DEPTH (`RF_CMD_FIFO_DEPTH)
  ) cmd_fifo_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .in_valid_i   (cmd_valid_i),
    .in_ready_o   (cmd_ready_o),
    .in_op_i      (cmd_op_i),
    .in_addr_a_i  (cmd_addr_a_i),
    .in_addr_b_i  (cmd_addr_b_i),
    .in_wdata_i   (cmd_wdata_i),
    .in_inject_i  (cmd_inject_i),
    .out_valid_o  (q_valid),
    .out_ready_i  (q_ready),
    .out_op_o     (q_op),
    .out_addr_a_o (q_addr_a),
    .out_addr_b_o (q_addr_b),
    .out_wdata_o  (q_wdata),
    .out_inject_o (q_inject)
  );

  rf_access_ctrl rf_access_ctrl_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .cmd_valid_i   (q_valid),
    .cmd_ready_o   (q_ready),
    .cmd_op_i      (q_op),
    .cmd_addr_a_i  (q_addr_a),
    .cmd_addr_b_i  (q_addr_b),
    .cmd_wdata_i   (q_wdata),
    .cmd_inject_i  (q_inject),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .rf_we_o       (rf_we),
    .rf_inject_o   (rf_inject),
    .rf_rdata_a_i  (rf_rdata[0]),
    .rf_rdata_b_i  (rf_rdata[1]),
    .rf_ecc_err_i  (rf_ecc_err),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_rdata_a_o (rsp_rdata_a_o),
    .rsp_rdata_b_o (rsp_rdata_b_o),
    .rsp_ecc_err_o (rsp_ecc_err_o)
  );

  register_file_wrapper register_file_wrapper_i (
    .clk       (clk),
    .reset_i   (reset_i),
    .raddr_i   (rf_raddr),
    .rdata_o   (rf_rdata),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .inject_i  (rf_inject),
    .ecc_err_o (rf_ecc_err)
  );

endmodule

// ==== design/rf_types_pkg.sv ====
`include "rf_config.svh"

package rf_types_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Data path vectors
  //////////////////////////////////////////////////////////////////////////

  // Register index, wide enough for every register
  typedef logic [$clog2(`RF_NUM_REGS)-1:0] rf_addr_t;

  // Plain data word as seen outside the register file
  typedef logic [`RF_DATA_WIDTH-1:0] rf_data_t;

  // Check bits of one word
  typedef logic [`RF_ECC_WIDTH-1:0] rf_ecc_t;

  // Stored codeword
  // Check bits sit in the upper part, data in the lower part
  typedef logic [`RF_ECC_WIDTH+`RF_DATA_WIDTH-1:0] rf_word_t;

endpackage

// ==== files.f ====
+incdir+design
design/rf_types_pkg.sv
design/rf_cmd_pkg.sv
design/cmd_fifo.sv
design/register_file.sv
design/register_file_ecc.sv
design/register_file_wrapper.sv
design/rf_access_ctrl.sv
design/rf_subsys_top.sv
testbench/rf_checker.sv
testbench/rf_tb.sv

// ==== testbench/rf_checker.sv ====
`include "rf_config.svh"

module rf_checker (
  input  logic                   clk,
  input  logic                   reset_i,

  // Command port of the DUT
  input  logic                   cmd_valid_i,
  input  logic                   cmd_ready_i,
  input  rf_cmd_pkg::cmd_op_e    cmd_op_i,
  input  rf_types_pkg::rf_addr_t cmd_addr_a_i,
  input  rf_types_pkg::rf_addr_t cmd_addr_b_i,
  input  rf_types_pkg::rf_data_t cmd_wdata_i,
  input  logic                   cmd_inject_i,

  // Table values for the command on the port
  input  rf_types_pkg::rf_data_t exp_a_i,
  input  rf_types_pkg::rf_data_t exp_b_i,
  input  logic                   exp_err_i,

  // Response port of the DUT
  input  logic                   rsp_valid_i,
  input  logic                   rsp_ready_i,
  input  rf_types_pkg::rf_data_t rsp_rdata_a_i,
  input  rf_types_pkg::rf_data_t rsp_rdata_b_i,
  input  logic                   rsp_ecc_err_i,

  // Totals for the closing line
  output int                     error_count_o,
  output int                     read_count_o,
  output int                     rsp_count_o
);

  import rf_types_pkg::*;
  import rf_cmd_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Shadow model
  ////////////////////////////////////////////////////////////////////////////

  // Last written data and fault flag per register
  rf_data_t shadow_data [`RF_NUM_REGS];
  logic     shadow_inj  [`RF_NUM_REGS];

  // Predictions of reads still waiting for a response, oldest first
  rf_data_t pend_a   [$];
  rf_data_t pend_b   [$];
  logic     pend_err [$];

  int errors;
  int reads;
  int rsps;

  assign error_count_o = errors;
  assign read_count_o  = reads;
  assign rsp_count_o   = rsps;

  // Register 0 is hardwired zero
  // Injected fault shows up as data bit 0 inverted
  function automatic rf_data_t predict_word(input rf_addr_t addr);
    rf_data_t word;
    if (addr == '0) begin
      word = '0;
    end else begin
      word = shadow_data[addr] ^ rf_data_t'(shadow_inj[addr]);
    end
    return word;
  endfunction

  // Any faulty register on either port raises the flag
  function automatic logic predict_err(input rf_addr_t addr_a, input rf_addr_t addr_b);
    logic err;
    err = ((addr_a != '0) && shadow_inj[addr_a]) || ((addr_b != '0) && shadow_inj[addr_b]);
    return err;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Sampling on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    errors = 0;
    reads  = 0;
    rsps   = 0;
  end

  always @(posedge clk) begin : watch
    rf_data_t pa;
    rf_data_t pb;
    logic     perr;
    if (reset_i) begin
      for (int r = 0; r < `RF_NUM_REGS; r++) begin
        shadow_data[r] = '0;
        shadow_inj[r]  = 1'b0;
      end
    end else begin
      // Responses first, a read never answers on its own accept edge
      if (rsp_valid_i && rsp_ready_i) begin
        rsps++;
        if (pend_a.size() == 0) begin
          $display("error @%0t: response with no matching read", $time);
          errors++;
        end else begin
          pa   = pend_a.pop_front();
          pb   = pend_b.pop_front();
          perr = pend_err.pop_front();
          if (rsp_rdata_a_i !== pa) begin
            $display("error @%0t: port a got %h, expected %h", $time, rsp_rdata_a_i, pa);
            errors++;
          end
          if (rsp_rdata_b_i !== pb) begin
            $display("error @%0t: port b got %h, expected %h", $time, rsp_rdata_b_i, pb);
            errors++;
          end
          if (rsp_ecc_err_i !== perr) begin
            $display("error @%0t: ecc flag got %b, expected %b", $time, rsp_ecc_err_i, perr);
            errors++;
          end
        end
      end
      // Accepted command updates or queries the model
      if (cmd_valid_i && cmd_ready_i) begin
        if (cmd_op_i == CMD_WRITE) begin
          if (cmd_addr_a_i != '0) begin
            shadow_data[cmd_addr_a_i] = cmd_wdata_i;
            shadow_inj[cmd_addr_a_i]  = cmd_inject_i;
          end
        end else begin
          pa   = predict_word(cmd_addr_a_i);
          pb   = predict_word(cmd_addr_b_i);
          perr = predict_err(cmd_addr_a_i, cmd_addr_b_i);
          if (pa !== exp_a_i || pb !== exp_b_i || perr !== exp_err_i) begin
            $display("error @%0t: table and model disagree on read r%0d r%0d",
                     $time, cmd_addr_a_i, cmd_addr_b_i);
            errors++;
          end
          pend_a.push_back(pa);
          pend_b.push_back(pb);
          pend_err.push_back(perr);
          reads++;
        end
      end
    end
  end

endmodule

// ==== testbench/rf_tb.sv ====
`include "rf_config.svh"

module rf_tb;

  import rf_types_pkg::*;
  import rf_cmd_pkg::*;

  localparam int          CLK_PERIOD     = 100;
  localparam int          RESET_CYCLES   = 5;
  localparam int          TABLE_LEN      = 36;
  localparam int          TIMEOUT_CYCLES = TABLE_LEN * 20;
  localparam logic [31:0] LFSR_SEED      = 32'hda41_6a50;

  logic     clk;
  logic     reset;
  logic     cmd_valid;
  logic     cmd_ready;
  cmd_op_e  cmd_op;
  rf_addr_t cmd_addr_a;
  rf_addr_t cmd_addr_b;
  rf_data_t cmd_wdata;
  logic     cmd_inject;
  logic     rsp_valid;
  logic     rsp_ready;
  rf_data_t rsp_rdata_a;
  rf_data_t rsp_rdata_b;
  logic     rsp_ecc_err;

  // Table values travelling with the command on the port
  rf_data_t exp_a;
  rf_data_t exp_b;
  logic     exp_err;

  ////////////////////////////////////////////////////////////////////////////
  // Command table
  ////////////////////////////////////////////////////////////////////////////

  cmd_op_e  tbl_op      [TABLE_LEN];
  rf_addr_t tbl_addr_a  [TABLE_LEN];
  rf_addr_t tbl_addr_b  [TABLE_LEN];
  rf_data_t tbl_wdata   [TABLE_LEN];
  logic     tbl_inject  [TABLE_LEN];
  rf_data_t tbl_exp_a   [TABLE_LEN];
  rf_data_t tbl_exp_b   [TABLE_LEN];
  logic     tbl_exp_err [TABLE_LEN];
  int       tbl_fill;
  int       num_reads;

  int          error_count;
  int          read_count;
  int          rsp_count;
  int          cycle_count;
  logic [31:0] lfsr = LFSR_SEED;

  task automatic add_write(input rf_addr_t addr, input rf_data_t data, input logic inject);
    tbl_op[tbl_fill]      = CMD_WRITE;
    tbl_addr_a[tbl_fill]  = addr;
    tbl_addr_b[tbl_fill]  = '0;
    tbl_wdata[tbl_fill]   = data;
    tbl_inject[tbl_fill]  = inject;
    tbl_exp_a[tbl_fill]   = '0;
    tbl_exp_b[tbl_fill]   = '0;
    tbl_exp_err[tbl_fill] = 1'b0;
    tbl_fill++;
  endtask

  task automatic add_read(input rf_addr_t addr_a, input rf_addr_t addr_b,
                          input rf_data_t word_a, input rf_data_t word_b, input logic err);
    tbl_op[tbl_fill]      = CMD_READ;
    tbl_addr_a[tbl_fill]  = addr_a;
    tbl_addr_b[tbl_fill]  = addr_b;
    tbl_wdata[tbl_fill]   = '0;
    tbl_inject[tbl_fill]  = 1'b0;
    tbl_exp_a[tbl_fill]   = word_a;
    tbl_exp_b[tbl_fill]   = word_b;
    tbl_exp_err[tbl_fill] = err;
    tbl_fill++;
    num_reads++;
  endtask

  task automatic build_table();
    tbl_fill  = 0;
    num_reads = 0;
    // Every register reads zero after reset
    for (int r = 0; r < `RF_NUM_REGS; r += 2) begin
      add_read(rf_addr_t'(r), rf_addr_t'(r + 1), '0, '0, 1'b0);
    end
    // Write then read on both ports
    add_write(5'd5, 32'h1234_5678, 1'b0);
    add_write(5'd10, 32'hcafe_f00d, 1'b0);
    add_read(5'd5, 5'd10, 32'h1234_5678, 32'hcafe_f00d, 1'b0);
    add_read(5'd10, 5'd5, 32'hcafe_f00d, 32'h1234_5678, 1'b0);
    // Register 0 ignores writes
    add_write(5'd0, 32'hdead_beef, 1'b0);
    add_read(5'd0, 5'd5, '0, 32'h1234_5678, 1'b0);
    // Fault injection then a clean rewrite
    add_write(5'd7, 32'ha5a5_0f0f, 1'b1);
    add_read(5'd7, 5'd7, 32'ha5a5_0f0e, 32'ha5a5_0f0e, 1'b1);
    // Faulty word on one port only, each side in turn
    add_read(5'd5, 5'd7, 32'h1234_5678, 32'ha5a5_0f0e, 1'b1);
    add_read(5'd7, 5'd5, 32'ha5a5_0f0e, 32'h1234_5678, 1'b1);
    add_write(5'd7, 32'h0f0f_a5a5, 1'b0);
    add_read(5'd7, 5'd5, 32'h0f0f_a5a5, 32'h1234_5678, 1'b0);
    // Burst longer than the FIFO
    add_write(5'd12, 32'h1111_2222, 1'b0);
    add_write(5'd13, 32'h3333_4444, 1'b0);
    add_read(5'd12, 5'd13, 32'h1111_2222, 32'h3333_4444, 1'b0);
    add_read(5'd13, 5'd12, 32'h3333_4444, 32'h1111_2222, 1'b0);
    add_write(5'd31, 32'hffff_ffff, 1'b0);
    add_read(5'd31, 5'd0, 32'hffff_ffff, '0, 1'b0);
    add_read(5'd12, 5'd31, 32'h1111_2222, 32'hffff_ffff, 1'b0);
    add_read(5'd10, 5'd13, 32'hcafe_f00d, 32'h3333_4444, 1'b0);
  endtask

  task automatic apply_entry(input int idx);
    cmd_valid  <= 1'b1;
    cmd_op     <= tbl_op[idx];
    cmd_addr_a <= tbl_addr_a[idx];
    cmd_addr_b <= tbl_addr_b[idx];
    cmd_wdata  <= tbl_wdata[idx];
    cmd_inject <= tbl_inject[idx];
    exp_a      <= tbl_exp_a[idx];
    exp_b      <= tbl_exp_b[idx];
    exp_err    <= tbl_exp_err[idx];
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Clock, DUT and checker
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  rf_subsys_top dut (
    .clk           (clk),
    .reset_i       (reset),
    .cmd_valid_i   (cmd_valid),
    .cmd_ready_o   (cmd_ready),
    .cmd_op_i      (cmd_op),
    .cmd_addr_a_i  (cmd_addr_a),
    .cmd_addr_b_i  (cmd_addr_b),
    .cmd_wdata_i   (cmd_wdata),
    .cmd_inject_i  (cmd_inject),
    .rsp_valid_o   (rsp_valid),
    .rsp_ready_i   (rsp_ready),
    .rsp_rdata_a_o (rsp_rdata_a),
    .rsp_rdata_b_o (rsp_rdata_b),
    .rsp_ecc_err_o (rsp_ecc_err)
  );

  rf_checker chk (
    .clk           (clk),
    .reset_i       (reset),
    .cmd_valid_i   (cmd_valid),
    .cmd_ready_i   (cmd_ready),
    .cmd_op_i      (cmd_op),
    .cmd_addr_a_i  (cmd_addr_a),
    .cmd_addr_b_i  (cmd_addr_b),
    .cmd_wdata_i   (cmd_wdata),
    .cmd_inject_i  (cmd_inject),
    .exp_a_i       (exp_a),
    .exp_b_i       (exp_b),
    .exp_err_i     (exp_err),
    .rsp_valid_i   (rsp_valid),
    .rsp_ready_i   (rsp_ready),
    .rsp_rdata_a_i (rsp_rdata_a),
    .rsp_rdata_b_i (rsp_rdata_b),
    .rsp_ecc_err_i (rsp_ecc_err),
    .error_count_o (error_count),
    .read_count_o  (read_count),
    .rsp_count_o   (rsp_count)
  );

  // Random response back-pressure with one LFSR step per bit
  initial begin
    rsp_ready = 1'b0;
    forever begin
      @(posedge clk);
      if (reset) begin
        rsp_ready <= 1'b0;
      end else begin
        lfsr = next_lfsr(lfsr);
        rsp_ready <= lfsr[0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset      = 1'b1;
    cmd_valid  = 1'b0;
    cmd_op     = CMD_READ;
    cmd_addr_a = '0;
    cmd_addr_b = '0;
    cmd_wdata  = '0;
    cmd_inject = 1'b0;
    exp_a      = '0;
    exp_b      = '0;
    exp_err    = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    // Each entry held until the buffer takes it
    for (int i = 0; i < TABLE_LEN; i++) begin
      apply_entry(i);
      @(posedge clk);
      while (!cmd_ready) @(posedge clk);
    end
    cmd_valid <= 1'b0;
    while (rsp_count < num_reads) @(posedge clk);
    // Quiet period where late duplicates would show up
    repeat (20) @(posedge clk);
    $display("Summary: %0d reads, %0d responses, %0d errors", read_count, rsp_count, error_count);
    if (error_count == 0 && read_count == num_reads && rsp_count == num_reads) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, only %0d of %0d responses arrived",
             cycle_count, rsp_count, num_reads);
    $display("Test failed");
    $finish;
  end

endmodule
